// File: Bender.yml
package:
  name: tec_ctl

sources:
  - include_dirs:
      - hw
    files:
      - hw/tec_pkg.sv
      - hw/console_seq.sv
      - hw/console_ctl.sv
      - hw/instr_decode.sv
      - hw/ctl_out.sv
      - hw/tec_ctl_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/tec_ctl_checker.sv
      - verification/tec_ctl_tb.sv

// File: all.f
+incdir+hw
hw/tec_pkg.sv
hw/console_seq.sv
hw/console_ctl.sv
hw/instr_decode.sv
hw/ctl_out.sv
hw/tec_ctl_top.sv
verification/tec_ctl_checker.sv
verification/tec_ctl_tb.sv

// File: hw/console_ctl.sv
`timescale 1ns/1ps

`include "tec_cfg.svh"

module console_ctl (
    input  logic [2:0]            sw,
    input  logic                  st0,
    input  logic [3:1]            w,
    output logic [`TEC_CTL_W-1:0] con_ctl,
    output tec_pkg::sel_u         con_sel,
    output logic                  con_short,
    output logic                  con_long,
    output logic                  sst0
);

    logic w12;

    assign w12 = w[1] | w[2];

    // Console cycles never stretch
    assign con_long = 1'b0;

    always_comb begin
        con_ctl   = '0;
        con_sel   = '0;
        con_short = 1'b0;
        sst0      = 1'b0;

        case (sw)
            `TEC_SW_WMEM: begin
                con_ctl[`TEC_CTL_LAR]    = w[1] & ~st0; // address first
                con_ctl[`TEC_CTL_MEMW]   = w[1] & st0;
                con_ctl[`TEC_CTL_ARINC]  = w[1] & st0;
                con_ctl[`TEC_CTL_SBUS]   = w[1];
                con_ctl[`TEC_CTL_STOP]   = w[1];
                con_ctl[`TEC_CTL_SELCTL] = w[1];
                con_short                = w[1];
                sst0                     = w[1];
            end

            `TEC_SW_RMEM: begin
                con_ctl[`TEC_CTL_SBUS]   = w[1] & ~st0;
                con_ctl[`TEC_CTL_LAR]    = w[1] & ~st0;
                sst0                     = w[1] & ~st0;
                con_ctl[`TEC_CTL_MBUS]   = w[1] & st0;
                con_ctl[`TEC_CTL_ARINC]  = w[1] & st0;
                con_ctl[`TEC_CTL_STOP]   = w[1];
                con_ctl[`TEC_CTL_SELCTL] = w[1];
                con_short                = w[1];
            end

            `TEC_SW_RREG: begin
                con_ctl[`TEC_CTL_SELCTL] = w12;
                con_ctl[`TEC_CTL_STOP]   = w12;
                // R0/R1 on w1, R2/R3 on w2
                con_sel.pair.rd          = {w[2], 1'b0};
                con_sel.pair.rs          = {w[2], w12};
            end

            `TEC_SW_WREG: begin
                con_ctl[`TEC_CTL_SBUS]   = w12;
                con_ctl[`TEC_CTL_SELCTL] = w12;
                con_ctl[`TEC_CTL_DRW]    = w12;
                con_ctl[`TEC_CTL_STOP]   = w12;
                sst0                     = w[2] & ~st0; // second pass next
                con_sel.pair.rd          = {st0, w[2]};
                con_sel.pair.rs          = {(~st0 & w[1]) | (st0 & w[2]), w[1]};
            end

            `TEC_SW_RUN: begin
                // Load start address into PC once
                if (!st0) begin
                    con_ctl[`TEC_CTL_LPC]  = w[1];
                    con_ctl[`TEC_CTL_SBUS] = w[1];
                    con_ctl[`TEC_CTL_STOP] = w[1];
                    con_short              = w[1];
                    sst0                   = w[1];
                end
            end

            default: begin
                con_ctl = '0;
            end
        endcase
    end

endmodule

// File: hw/console_seq.sv
`timescale 1ns/1ps

`include "tec_cfg.svh"

module console_seq (
    input  logic       t3,
    input  logic       rst_n,
    input  logic [2:0] sw,
    input  logic       w2,
    input  logic       sst0,
    output logic       st0,
    output logic       run
);

    logic wreg_done;

    // Second pass of register write ends on its w2 beat
    assign wreg_done = (sw == `TEC_SW_WREG) && st0 && w2;

    // State steps on the falling edge of t3
    always_ff @(negedge t3) begin
        if (!rst_n) begin
            st0 <= 1'b0;
        end else if (sst0) begin
            st0 <= 1'b1;
        end else if (wreg_done) begin
            st0 <= 1'b0;
        end
    end

    // Program execution phase
    assign run = (sw == `TEC_SW_RUN) && st0;

endmodule

// File: hw/ctl_out.sv
`timescale 1ns/1ps

`include "tec_cfg.svh"

module ctl_out (
    input  logic                  rst_n,
    input  logic                  run,
    input  logic [`TEC_CTL_W-1:0] con_ctl,
    input  tec_pkg::sel_u         con_sel,
    input  logic                  con_short,
    input  logic                  con_long,
    input  logic [`TEC_CTL_W-1:0] exe_ctl,
    input  logic [3:0]            exe_s,
    input  logic                  exe_short,
    input  logic                  exe_long,
    output logic                  ldc,
    output logic                  ldz,
    output logic                  cin,
    output logic                  m,
    output logic                  abus,
    output logic                  drw,
    output logic                  pcinc,
    output logic                  lpc,
    output logic                  lar,
    output logic                  pcadd,
    output logic                  arinc,
    output logic                  selctl,
    output logic                  memw,
    output logic                  stop,
    output logic                  lir,
    output logic                  sbus,
    output logic                  mbus,
    output logic [3:0]            s,
    output tec_pkg::sel_u         sel,
    output logic                  short_cyc,
    output logic                  long_cyc
);

    import tec_pkg::*;

    logic [`TEC_CTL_W-1:0] ctl_v;
    sel_u                  sel_v;

    always_comb begin
        ctl_v     = '0;
        sel_v     = '0;
        s         = '0;
        short_cyc = 1'b0;
        long_cyc  = 1'b0;
        if (rst_n) begin
            if (run) begin
                ctl_v     = exe_ctl; // sel stays 0
                s         = exe_s;
                short_cyc = exe_short;
                long_cyc  = exe_long;
            end else begin
                ctl_v     = con_ctl;
                sel_v     = con_sel;
                short_cyc = con_short;
                long_cyc  = con_long;
            end
        end
    end

    assign sel    = sel_v;
    assign ldc    = ctl_v[`TEC_CTL_LDC];
    assign ldz    = ctl_v[`TEC_CTL_LDZ];
    assign cin    = ctl_v[`TEC_CTL_CIN];
    assign m      = ctl_v[`TEC_CTL_M];
    assign abus   = ctl_v[`TEC_CTL_ABUS];
    assign drw    = ctl_v[`TEC_CTL_DRW];
    assign pcinc  = ctl_v[`TEC_CTL_PCINC];
    assign lpc    = ctl_v[`TEC_CTL_LPC];
    assign lar    = ctl_v[`TEC_CTL_LAR];
    assign pcadd  = ctl_v[`TEC_CTL_PCADD];
    assign arinc  = ctl_v[`TEC_CTL_ARINC];
    assign selctl = ctl_v[`TEC_CTL_SELCTL];
    assign memw   = ctl_v[`TEC_CTL_MEMW];
    assign stop   = ctl_v[`TEC_CTL_STOP];
    assign lir    = ctl_v[`TEC_CTL_LIR];
    assign sbus   = ctl_v[`TEC_CTL_SBUS];
    assign mbus   = ctl_v[`TEC_CTL_MBUS];

endmodule

// File: hw/instr_decode.sv
`timescale 1ns/1ps

`include "tec_cfg.svh"

module instr_decode (
    input  logic [7:4]            ir,
    input  logic [3:1]            w,
    input  logic                  c,
    input  logic                  z,
    output logic [`TEC_CTL_W-1:0] exe_ctl,
    output logic [3:0]            exe_s,
    output logic                  exe_short,
    output logic                  exe_long
);

    logic take_jump;

    // Every instruction takes its fetch beat
    assign exe_short = 1'b0;

    assign take_jump = ((ir == `TEC_OP_JC) && c) || ((ir == `TEC_OP_JZ) && z);

    always_comb begin
        exe_ctl  = '0;
        exe_s    = '0;
        exe_long = 1'b0;

        // Fetch on w1
        exe_ctl[`TEC_CTL_LIR]   = w[1];
        exe_ctl[`TEC_CTL_PCINC] = w[1];

        case (ir)
            `TEC_OP_ADD, `TEC_OP_SUB, `TEC_OP_INC,
            `TEC_OP_AND, `TEC_OP_OR, `TEC_OP_XOR: begin
                exe_ctl[`TEC_CTL_ABUS] = w[2];
                exe_ctl[`TEC_CTL_DRW]  = w[2];
                exe_ctl[`TEC_CTL_LDZ]  = w[2];
                case (ir)
                    `TEC_OP_ADD: begin
                        exe_s                  = `TEC_ALU_ADD;
                        exe_ctl[`TEC_CTL_LDC]  = w[2];
                        exe_ctl[`TEC_CTL_CIN]  = w[2];
                    end
                    `TEC_OP_SUB: begin
                        exe_s                  = `TEC_ALU_SUB;
                        exe_ctl[`TEC_CTL_LDC]  = w[2];
                    end
                    `TEC_OP_INC: begin
                        exe_s                  = `TEC_ALU_INC;
                        exe_ctl[`TEC_CTL_LDC]  = w[2];
                    end
                    `TEC_OP_AND: begin
                        exe_s                  = `TEC_ALU_AND;
                        exe_ctl[`TEC_CTL_M]    = w[2];
                    end
                    `TEC_OP_OR: begin
                        exe_s                  = `TEC_ALU_OR;
                        exe_ctl[`TEC_CTL_M]    = w[2];
                    end
                    default: begin
                        exe_s                  = `TEC_ALU_SUB; // XOR in logic mode
                        exe_ctl[`TEC_CTL_M]    = w[2];
                    end
                endcase
            end

            `TEC_OP_LD: begin
                exe_s                   = `TEC_ALU_PASS_A;
                exe_ctl[`TEC_CTL_M]     = w[2];
                exe_ctl[`TEC_CTL_ABUS]  = w[2]; // address from Rs
                exe_ctl[`TEC_CTL_LAR]   = w[2];
                exe_long                = w[2];
                exe_ctl[`TEC_CTL_DRW]   = w[3];
                exe_ctl[`TEC_CTL_MBUS]  = w[3];
            end

            `TEC_OP_ST: begin
                exe_s                   = w[2] ? `TEC_ALU_ONES : `TEC_ALU_PASS_A;
                exe_ctl[`TEC_CTL_M]     = w[2] | w[3];
                exe_ctl[`TEC_CTL_ABUS]  = w[2] | w[3];
                exe_ctl[`TEC_CTL_LAR]   = w[2];
                exe_long                = w[2];
                exe_ctl[`TEC_CTL_MEMW]  = w[3];
            end

            `TEC_OP_JC, `TEC_OP_JZ: begin
                exe_ctl[`TEC_CTL_PCADD] = w[2] & take_jump;
            end

            `TEC_OP_OUT: begin
                exe_s                   = `TEC_ALU_PASS_A;
                exe_ctl[`TEC_CTL_M]     = w[2];
                exe_ctl[`TEC_CTL_ABUS]  = w[2];
            end

            `TEC_OP_STP: begin
                exe_ctl[`TEC_CTL_STOP]  = w[2];
            end

            default: begin
                exe_s = '0; // fetch only
            end
        endcase
    end

endmodule

// File: hw/tec_cfg.svh
`ifndef TEC_CFG_SVH
`define TEC_CFG_SVH

// Console switch settings sw[2:0]
`define TEC_SW_RUN      3'b000
`define TEC_SW_WMEM     3'b001
`define TEC_SW_RMEM     3'b010
`define TEC_SW_RREG     3'b011
`define TEC_SW_WREG     3'b100

// Opcode field ir[7:4]
`define TEC_OP_ADD      4'b0001
`define TEC_OP_SUB      4'b0010
`define TEC_OP_AND      4'b0011
`define TEC_OP_INC      4'b0100
`define TEC_OP_LD       4'b0101
`define TEC_OP_ST       4'b0110
`define TEC_OP_JC       4'b0111
`define TEC_OP_JZ       4'b1000
`define TEC_OP_OUT      4'b1010
`define TEC_OP_OR       4'b1100
`define TEC_OP_XOR      4'b1101
`define TEC_OP_STP      4'b1110

// ALU function select s[3:0], m picks arithmetic or logic
`define TEC_ALU_ADD     4'b1001
`define TEC_ALU_SUB     4'b0110 // also XOR when m is high
`define TEC_ALU_AND     4'b1011
`define TEC_ALU_OR      4'b1110
`define TEC_ALU_PASS_A  4'b1010
`define TEC_ALU_ONES    4'b1111
`define TEC_ALU_INC     4'b0000 // A plus carry

// Single-bit control vector
`define TEC_CTL_W       17
`define TEC_CTL_LDC     0
`define TEC_CTL_LDZ     1
`define TEC_CTL_CIN     2
`define TEC_CTL_M       3
`define TEC_CTL_ABUS    4
`define TEC_CTL_DRW     5
`define TEC_CTL_PCINC   6
`define TEC_CTL_LPC     7
`define TEC_CTL_LAR     8
`define TEC_CTL_PCADD   9
`define TEC_CTL_ARINC   10
`define TEC_CTL_SELCTL  11
`define TEC_CTL_MEMW    12
`define TEC_CTL_STOP    13
`define TEC_CTL_LIR     14
`define TEC_CTL_SBUS    15
`define TEC_CTL_MBUS    16

`endif

// File: hw/tec_ctl_top.sv
`timescale 1ns/1ps

`include "tec_cfg.svh"

module tec_ctl_top (
    input  logic          t3,
    input  logic          rst_n,
    input  logic          c,
    input  logic          z,
    input  logic [2:0]    sw,
    input  logic [7:4]    ir,
    input  logic [3:1]    w,
    output logic          ldc,
    output logic          ldz,
    output logic          cin,
    output logic          m,
    output logic          abus,
    output logic          drw,
    output logic          pcinc,
    output logic          lpc,
    output logic          lar,
    output logic          pcadd,
    output logic          arinc,
    output logic          selctl,
    output logic          memw,
    output logic          stop,
    output logic          lir,
    output logic          sbus,
    output logic          mbus,
    output logic [3:0]    s,
    output tec_pkg::sel_u sel,
    output logic          short_cyc,
    output logic          long_cyc
);

    import tec_pkg::*;

    logic                  st0;
    logic                  run;
    logic                  sst0;
    logic [`TEC_CTL_W-1:0] con_ctl;
    sel_u                  con_sel;
    logic                  con_short;
    logic                  con_long;
    logic [`TEC_CTL_W-1:0] exe_ctl;
    logic [3:0]            exe_s;
    logic                  exe_short;
    logic                  exe_long;

    console_seq u_seq (
        .t3   (t3),
        .rst_n(rst_n),
        .sw   (sw),
        .w2   (w[2]),
        .sst0 (sst0),
        .st0  (st0),
        .run  (run)
    );

    console_ctl u_con (
        .sw       (sw),
        .st0      (st0),
        .w        (w),
        .con_ctl  (con_ctl),
        .con_sel  (con_sel),
        .con_short(con_short),
        .con_long (con_long),
        .sst0     (sst0)
    );

    instr_decode u_dec (
        .ir       (ir),
        .w        (w),
        .c        (c),
        .z        (z),
        .exe_ctl  (exe_ctl),
        .exe_s    (exe_s),
        .exe_short(exe_short),
        .exe_long (exe_long)
    );

    ctl_out u_out (
        .rst_n    (rst_n),
        .run      (run),
        .con_ctl  (con_ctl),
        .con_sel  (con_sel),
        .con_short(con_short),
        .con_long (con_long),
        .exe_ctl  (exe_ctl),
        .exe_s    (exe_s),
        .exe_short(exe_short),
        .exe_long (exe_long),
        .ldc      (ldc),
        .ldz      (ldz),
        .cin      (cin),
        .m        (m),
        .abus     (abus),
        .drw      (drw),
        .pcinc    (pcinc),
        .lpc      (lpc),
        .lar      (lar),
        .pcadd    (pcadd),
        .arinc    (arinc),
        .selctl   (selctl),
        .memw     (memw),
        .stop     (stop),
        .lir      (lir),
        .sbus     (sbus),
        .mbus     (mbus),
        .s        (s),
        .sel      (sel),
        .short_cyc(short_cyc),
        .long_cyc (long_cyc)
    );

endmodule

// File: hw/tec_pkg.sv
package tec_pkg;

    // Register pair, rd written by drw and rs driven onto the bus
    typedef struct packed {
        logic [1:0] rd;
        logic [1:0] rs;
    } sel_pair_t;

    // Register select word, seen as the raw bus or as the pair
    typedef union packed {
        logic [3:0] raw;
        sel_pair_t  pair;
    } sel_u;

endpackage

// File: verification/tec_ctl_checker.sv
`timescale 1ns/1ps

module tec_ctl_checker (
    input logic          t3,
    input logic          rst_n,
    input logic          ldc,
    input logic          ldz,
    input logic          cin,
    input logic          m,
    input logic          abus,
    input logic          drw,
    input logic          pcinc,
    input logic          lpc,
    input logic          lar,
    input logic          pcadd,
    input logic          arinc,
    input logic          selctl,
    input logic          memw,
    input logic          stop,
    input logic          lir,
    input logic          sbus,
    input logic          mbus,
    input logic [3:0]    s,
    input tec_pkg::sel_u sel,
    input logic          short_cyc,
    input logic          long_cyc
);

    int          fail_count = 0;
    logic [26:0] all_out;

    assign all_out = {ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd, arinc, selctl,
                      memw, stop, lir, sbus, mbus, s, sel.raw, short_cyc, long_cyc};

    // Address load and memory write never share a beat
    memw_lar_excl: assert property (@(posedge t3) !(memw && lar))
        else begin
            fail_count++;
            $error("memw and lar high together");
        end

    sel_needs_selctl: assert property (@(posedge t3) (sel.raw != 4'h0) |-> selctl)
        else begin
            fail_count++;
            $error("sel nonzero without selctl");
        end

    lir_stop_excl: assert property (@(posedge t3) !(lir && stop))
        else begin
            fail_count++;
            $error("lir and stop high together");
        end

    // Everything blanked in reset
    reset_quiet: assert property (@(posedge t3) !rst_n |-> (all_out == '0))
        else begin
            fail_count++;
            $error("output active while rst_n low");
        end

endmodule

bind tec_ctl_top tec_ctl_checker u_chk (.*);

// File: verification/tec_ctl_tb.sv
`timescale 1ns/1ps

`include "tec_cfg.svh"

module tec_ctl_tb;

    localparam int num_rows   = 31;
    localparam int max_cycles = 8 + 2 * num_rows + 20;
    localparam logic [1:0] flag_any = 2'd2; // flag picked at random

    localparam logic [`TEC_CTL_W-1:0] one      = 1;
    localparam logic [`TEC_CTL_W-1:0] ldc_m    = one << `TEC_CTL_LDC;
    localparam logic [`TEC_CTL_W-1:0] ldz_m    = one << `TEC_CTL_LDZ;
    localparam logic [`TEC_CTL_W-1:0] cin_m    = one << `TEC_CTL_CIN;
    localparam logic [`TEC_CTL_W-1:0] m_m      = one << `TEC_CTL_M;
    localparam logic [`TEC_CTL_W-1:0] abus_m   = one << `TEC_CTL_ABUS;
    localparam logic [`TEC_CTL_W-1:0] drw_m    = one << `TEC_CTL_DRW;
    localparam logic [`TEC_CTL_W-1:0] pcinc_m  = one << `TEC_CTL_PCINC;
    localparam logic [`TEC_CTL_W-1:0] lpc_m    = one << `TEC_CTL_LPC;
    localparam logic [`TEC_CTL_W-1:0] lar_m    = one << `TEC_CTL_LAR;
    localparam logic [`TEC_CTL_W-1:0] pcadd_m  = one << `TEC_CTL_PCADD;
    localparam logic [`TEC_CTL_W-1:0] arinc_m  = one << `TEC_CTL_ARINC;
    localparam logic [`TEC_CTL_W-1:0] selctl_m = one << `TEC_CTL_SELCTL;
    localparam logic [`TEC_CTL_W-1:0] memw_m   = one << `TEC_CTL_MEMW;
    localparam logic [`TEC_CTL_W-1:0] stop_m   = one << `TEC_CTL_STOP;
    localparam logic [`TEC_CTL_W-1:0] lir_m    = one << `TEC_CTL_LIR;
    localparam logic [`TEC_CTL_W-1:0] sbus_m   = one << `TEC_CTL_SBUS;
    localparam logic [`TEC_CTL_W-1:0] mbus_m   = one << `TEC_CTL_MBUS;

    logic          t3;
    logic          rst_n;
    logic          c;
    logic          z;
    logic [2:0]    sw;
    logic [7:4]    ir;
    logic [3:1]    w;
    logic          ldc;
    logic          ldz;
    logic          cin;
    logic          m;
    logic          abus;
    logic          drw;
    logic          pcinc;
    logic          lpc;
    logic          lar;
    logic          pcadd;
    logic          arinc;
    logic          selctl;
    logic          memw;
    logic          stop;
    logic          lir;
    logic          sbus;
    logic          mbus;
    logic [3:0]    s;
    tec_pkg::sel_u sel;
    logic          short_cyc;
    logic          long_cyc;

    logic [2:0]            tab_sw    [num_rows];
    logic [3:0]            tab_ir    [num_rows];
    logic [3:1]            tab_w     [num_rows];
    logic [1:0]            tab_c     [num_rows];
    logic [1:0]            tab_z     [num_rows];
    logic [`TEC_CTL_W-1:0] tab_ctl   [num_rows];
    logic [3:0]            tab_s     [num_rows];
    tec_pkg::sel_u         tab_sel   [num_rows];
    logic                  tab_short [num_rows];
    logic                  tab_long  [num_rows];
    int                    row_count = 0;
    int                    cycle_count = 0;

    tec_ctl_top DUT (.*);

    always #10 t3 = ~t3;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    always @(posedge t3) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles)
            fail_run($sformatf("Timeout after %0d clock cycles", max_cycles));
    end

    task automatic add_row(input logic [2:0] r_sw, input logic [3:0] r_ir, input logic [3:1] r_w,
                           input logic [1:0] r_c, input logic [1:0] r_z,
                           input logic [`TEC_CTL_W-1:0] r_ctl, input logic [3:0] r_s,
                           input logic [3:0] r_sel, input logic r_short, input logic r_long);
        if (row_count >= num_rows)
            fail_run("Stimulus table has more rows than its arrays hold");
        tab_sw[row_count]    = r_sw;
        tab_ir[row_count]    = r_ir;
        tab_w[row_count]     = r_w;
        tab_c[row_count]     = r_c;
        tab_z[row_count]     = r_z;
        tab_ctl[row_count]   = r_ctl;
        tab_s[row_count]     = r_s;
        tab_sel[row_count]   = r_sel;
        tab_short[row_count] = r_short;
        tab_long[row_count]  = r_long;
        row_count++;
    endtask

    task automatic build_table();
        logic [`TEC_CTL_W-1:0] wreg_lines;
        logic [`TEC_CTL_W-1:0] alu_lines;
        wreg_lines = sbus_m | selctl_m | drw_m | stop_m;
        alu_lines  = abus_m | drw_m | ldz_m;
        // Write memory loads the address first, then writes
        add_row(`TEC_SW_WMEM, 4'h0, 3'b001, flag_any, flag_any,
                lar_m | sbus_m | stop_m | selctl_m, 4'h0, 4'h0, 1'b1, 1'b0);
        add_row(`TEC_SW_WMEM, 4'h0, 3'b001, flag_any, flag_any,
                memw_m | arinc_m | sbus_m | stop_m | selctl_m, 4'h0, 4'h0, 1'b1, 1'b0);
        add_row(`TEC_SW_WREG, 4'h0, 3'b010, flag_any, flag_any, wreg_lines, 4'h0, 4'he, 1'b0, 1'b0);
        add_row(`TEC_SW_RMEM, 4'h0, 3'b001, flag_any, flag_any,
                lar_m | sbus_m | stop_m | selctl_m, 4'h0, 4'h0, 1'b1, 1'b0);
        add_row(`TEC_SW_RMEM, 4'h0, 3'b001, flag_any, flag_any,
                mbus_m | arinc_m | stop_m | selctl_m, 4'h0, 4'h0, 1'b1, 1'b0);
        add_row(`TEC_SW_WREG, 4'h0, 3'b010, flag_any, flag_any, wreg_lines, 4'h0, 4'he, 1'b0, 1'b0);
        // Read registers
        add_row(`TEC_SW_RREG, 4'h0, 3'b001, flag_any, flag_any,
                selctl_m | stop_m, 4'h0, 4'h1, 1'b0, 1'b0);
        add_row(`TEC_SW_RREG, 4'h0, 3'b010, flag_any, flag_any,
                selctl_m | stop_m, 4'h0, 4'hb, 1'b0, 1'b0);
        // Write registers over two passes
        add_row(`TEC_SW_WREG, 4'h0, 3'b001, flag_any, flag_any, wreg_lines, 4'h0, 4'h3, 1'b0, 1'b0);
        add_row(`TEC_SW_WREG, 4'h0, 3'b010, flag_any, flag_any, wreg_lines, 4'h0, 4'h4, 1'b0, 1'b0);
        add_row(`TEC_SW_WREG, 4'h0, 3'b001, flag_any, flag_any, wreg_lines, 4'h0, 4'h9, 1'b0, 1'b0);
        add_row(`TEC_SW_WREG, 4'h0, 3'b010, flag_any, flag_any, wreg_lines, 4'h0, 4'he, 1'b0, 1'b0);
        // Start of program run loads PC
        add_row(`TEC_SW_RUN, 4'h0, 3'b001, flag_any, flag_any,
                lpc_m | sbus_m | stop_m, 4'h0, 4'h0, 1'b1, 1'b0);
        add_row(`TEC_SW_RUN, `TEC_OP_ADD, 3'b001, flag_any, flag_any,
                lir_m | pcinc_m, `TEC_ALU_ADD, 4'h0, 1'b0, 1'b0);
        add_row(`TEC_SW_RUN, `TEC_OP_ADD, 3'b010, flag_any, flag_any,
                alu_lines | ldc_m | cin_m, `TEC_ALU_ADD, 4'h0, 1'b0, 1'b0);
        add_row(`TEC_SW_RUN, `TEC_OP_SUB, 3'b010, flag_any, flag_any,
                alu_lines | ldc_m, `TEC_ALU_SUB, 4'h0, 1'b0, 1'b0);
        add_row(`TEC_SW_RUN, `TEC_OP_AND, 3'b010, flag_any, flag_any,
                alu_lines | m_m, `TEC_ALU_AND, 4'h0, 1'b0, 1'b0);
        add_row(`TEC_SW_RUN, `TEC_OP_INC, 3'b010, flag_any, flag_any,
                alu_lines | ldc_m, `TEC_ALU_INC, 4'h0, 1'b0, 1'b0);
        add_row(`TEC_SW_RUN, `TEC_OP_OR, 3'b010, flag_any, flag_any,
                alu_lines | m_m, `TEC_ALU_OR, 4'h0, 1'b0, 1'b0);
        add_row(`TEC_SW_RUN, `TEC_OP_XOR, 3'b010, flag_any, flag_any,
                alu_lines | m_m, `TEC_ALU_SUB, 4'h0, 1'b0, 1'b0); // XOR shares the SUB code
        add_row(`TEC_SW_RUN, `TEC_OP_LD, 3'b010, flag_any, flag_any,
                m_m | abus_m | lar_m, `TEC_ALU_PASS_A, 4'h0, 1'b0, 1'b1);
        add_row(`TEC_SW_RUN, `TEC_OP_LD, 3'b100, flag_any, flag_any,
                drw_m | mbus_m, `TEC_ALU_PASS_A, 4'h0, 1'b0, 1'b0);
        add_row(`TEC_SW_RUN, `TEC_OP_ST, 3'b010, flag_any, flag_any,
                m_m | abus_m | lar_m, `TEC_ALU_ONES, 4'h0, 1'b0, 1'b1);
        add_row(`TEC_SW_RUN, `TEC_OP_ST, 3'b100, flag_any, flag_any,
                m_m | abus_m | memw_m, `TEC_ALU_PASS_A, 4'h0, 1'b0, 1'b0);
        // Conditional jumps for both flag values
        add_row(`TEC_SW_RUN, `TEC_OP_JC, 3'b010, 2'd1, flag_any, pcadd_m, 4'h0, 4'h0, 1'b0, 1'b0);
        add_row(`TEC_SW_RUN, `TEC_OP_JC, 3'b010, 2'd0, flag_any, '0, 4'h0, 4'h0, 1'b0, 1'b0);
        add_row(`TEC_SW_RUN, `TEC_OP_JZ, 3'b010, flag_any, 2'd1, pcadd_m, 4'h0, 4'h0, 1'b0, 1'b0);
        add_row(`TEC_SW_RUN, `TEC_OP_JZ, 3'b010, flag_any, 2'd0, '0, 4'h0, 4'h0, 1'b0, 1'b0);
        add_row(`TEC_SW_RUN, `TEC_OP_OUT, 3'b010, flag_any, flag_any,
                m_m | abus_m, `TEC_ALU_PASS_A, 4'h0, 1'b0, 1'b0);
        add_row(`TEC_SW_RUN, `TEC_OP_STP, 3'b010, flag_any, flag_any, stop_m, 4'h0, 4'h0, 1'b0, 1'b0);
        add_row(`TEC_SW_RUN, 4'hf, 3'b001, flag_any, flag_any,
                lir_m | pcinc_m, 4'h0, 4'h0, 1'b0, 1'b0); // unused opcode
        if (row_count != num_rows)
            fail_run("Stimulus table row count does not match its arrays");
    endtask

    function automatic logic pick_flag(input logic [1:0] code);
        logic [31:0] r;
        r = $urandom;
        return (code == flag_any) ? r[0] : code[0];
    endfunction

    function automatic logic [`TEC_CTL_W-1:0] gather_ctl();
        logic [`TEC_CTL_W-1:0] v;
        v = '0;
        v[`TEC_CTL_LDC]    = ldc;
        v[`TEC_CTL_LDZ]    = ldz;
        v[`TEC_CTL_CIN]    = cin;
        v[`TEC_CTL_M]      = m;
        v[`TEC_CTL_ABUS]   = abus;
        v[`TEC_CTL_DRW]    = drw;
        v[`TEC_CTL_PCINC]  = pcinc;
        v[`TEC_CTL_LPC]    = lpc;
        v[`TEC_CTL_LAR]    = lar;
        v[`TEC_CTL_PCADD]  = pcadd;
        v[`TEC_CTL_ARINC]  = arinc;
        v[`TEC_CTL_SELCTL] = selctl;
        v[`TEC_CTL_MEMW]   = memw;
        v[`TEC_CTL_STOP]   = stop;
        v[`TEC_CTL_LIR]    = lir;
        v[`TEC_CTL_SBUS]   = sbus;
        v[`TEC_CTL_MBUS]   = mbus;
        return v;
    endfunction

    task automatic check_ctl(input logic [`TEC_CTL_W-1:0] got, input logic [`TEC_CTL_W-1:0] exp,
                             input string tag);
        if (got !== exp)
            fail_run($sformatf("FAILED %s ctl: got %h expected %h", tag, got, exp));
    endtask

    task automatic check_s(input logic [3:0] got, input logic [3:0] exp, input string tag);
        if (got !== exp)
            fail_run($sformatf("FAILED %s s: got %h expected %h", tag, got, exp));
    endtask

    task automatic check_sel(input tec_pkg::sel_u got, input tec_pkg::sel_u exp,
                             input string tag);
        if (got.raw !== exp.raw)
            fail_run($sformatf("FAILED %s sel: got %h expected %h", tag, got.raw, exp.raw));
    endtask

    task automatic check_cycle(input logic got_short, input logic got_long,
                               input logic exp_short, input logic exp_long, input string tag);
        if (got_short !== exp_short)
            fail_run($sformatf("FAILED %s short_cyc: got %h expected %h", tag, got_short,
                               exp_short));
        if (got_long !== exp_long)
            fail_run($sformatf("FAILED %s long_cyc: got %h expected %h", tag, got_long,
                               exp_long));
    endtask

    task automatic check_assertions(input string tag);
        if (DUT.u_chk.fail_count != 0)
            fail_run($sformatf("Assertion checker reported a violation by %s", tag));
    endtask

    initial begin
        logic [31:0] rnd;
        string       tag;
        t3       = 1'b0;
        rst_n    = 1'b0;
        c        = 1'b0;
        z        = 1'b0;
        sw       = `TEC_SW_RUN;
        ir       = 4'h0;
        w        = 3'b000;
        void'($urandom(32'hce34_1aab));
        build_table();

        // Random inputs while held in reset
        repeat (8) begin
            @(posedge t3);
            rnd = $urandom;
            sw <= rnd[2:0];
            w  <= rnd[5:3];
            ir <= rnd[9:6];
            c  <= rnd[10];
            z  <= rnd[11];
            #5;
            check_ctl(gather_ctl(), '0, "reset");
            check_s(s, 4'h0, "reset");
            check_sel(sel, '0, "reset");
            check_cycle(short_cyc, long_cyc, 1'b0, 1'b0, "reset");
            check_assertions("reset");
        end

        @(posedge t3);
        rst_n <= 1'b1;
        sw    <= `TEC_SW_RUN;
        w     <= 3'b000; // keeps st0 at 0
        ir    <= 4'h0;

        for (int i = 0; i < num_rows; i++) begin
            @(posedge t3);
            sw <= tab_sw[i];
            ir <= tab_ir[i];
            w  <= tab_w[i];
            c  <= pick_flag(tab_c[i]);
            z  <= pick_flag(tab_z[i]);
            #5;  // before the falling edge moves st0
            tag = $sformatf("row %0d", i);
            check_ctl(gather_ctl(), tab_ctl[i], tag);
            check_s(s, tab_s[i], tag);
            check_sel(sel, tab_sel[i], tag);
            check_cycle(short_cyc, long_cyc, tab_short[i], tab_long[i], tag);
            check_assertions(tag);
        end

        @(posedge t3);
        #1;
        if (DUT.u_chk.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            fail_run("Assertion checker reported a violation on the last row");
        end
    end

endmodule
